// ==== vlog.f ====
+incdir+include
logic/dac_tpl_pkg.sv
logic/dac_tone_gen.sv
logic/dac_channel.sv
logic/dac_framer.sv
logic/dac_tpl_core.sv
tb/dac_tpl_tb.sv

// ==== tb/dac_tpl_tb.sv ====
// Testbench for the DAC transport layer: clock, reset, reference model and directed tests
`timescale 1ns/100ps

module dac_tpl_tb;

  // Guard macro may already be set by the tone generator's copy
  `undef dac_sine_table_svh
  `include "dac_sine_table.svh"

  logic clk;
  logic rst;
  logic dac_sync;
  logic dac_dds_format;
  dac_tpl_pkg::chan_cfg_t [dac_tpl_pkg::num_channels-1:0] cfg;
  logic [63:0] dac_ddata;
  logic link_ready;
  logic link_valid;
  dac_tpl_pkg::lane_word_u [dac_tpl_pkg::num_lanes-1:0] link_data;
  logic [1:0] dac_valid;
  logic [1:0] enable;
  int checks;
  int errors;
  logic timed_out;

  dac_tpl_core dut0 (
    .clk            (clk),
    .rst            (rst),
    .dac_sync       (dac_sync),
    .dac_dds_format (dac_dds_format),
    .cfg            (cfg),
    .dac_ddata      (dac_ddata),
    .dac_valid      (dac_valid),
    .link_ready     (link_ready),
    .link_valid     (link_valid),
    .link_data      (link_data),
    .enable         (enable)
  );

  always #5 clk = ~clk;

  // **************************************************
  // Reference model
  // **************************************************

  // Top phase byte: bits 5:0 index, bit 6 mirrors, bit 7 negates
  function automatic int sine_of(input logic [15:0] ph);
    logic [7:0] top;
    int idx;
    top = ph[15:8];
    idx = top[5:0];
    if (top[6]) idx = 63 - idx;
    if (top[7]) return -int'(dac_sine_quarter[idx]);
    else return int'(dac_sine_quarter[idx]);
  endfunction

  // Sample s of clock n counted from the sync clock
  function automatic logic [15:0] tone_value(input dac_tpl_pkg::tone_cfg_t tc, input int n,
                                             input int s);
    logic [15:0] ph;
    int prod;
    ph = tc.init + tc.incr * (2 * n + s);
    prod = $signed(tc.scale) * sine_of(ph);
    return 16'(prod >>> 15);
  endfunction

  function automatic logic [15:0] chan_tone(input dac_tpl_pkg::chan_cfg_t c, input int n,
                                            input int s, input logic fmt);
    logic [15:0] sum;
    sum = tone_value(c.tone0, n, s) + tone_value(c.tone1, n, s);
    // Offset binary
    sum[15] = sum[15] ^ fmt;
    return sum;
  endfunction

  // Sample index is 2*channel+sample
  function automatic logic [3:0][15:0] dma_samples(input logic [63:0] d);
    logic [3:0][15:0] smp;
    for (int c = 0; c < 2; c++) begin
      for (int s = 0; s < 2; s++) begin
        smp[2*c+s] = d[32*c + 16*s +: 16];
      end
    end
    return smp;
  endfunction

  // Both channels ramp alike, n clocks after a restart
  function automatic logic [3:0][15:0] ramp_samples(input int n);
    logic [3:0][15:0] smp;
    for (int c = 0; c < 2; c++) begin
      for (int s = 0; s < 2; s++) begin
        smp[2*c+s] = 16'(2 * n + s);
      end
    end
    return smp;
  endfunction

  // Octet k: high byte first, lane k mod 2, slot k div 2 from the top
  function automatic logic [1:0][31:0] frame_words(input logic [3:0][15:0] smp);
    logic [1:0][31:0] w;
    logic [7:0] oct;
    w = '0;
    for (int k = 0; k < 8; k++) begin
      oct = (k % 2 == 0) ? smp[k/2][15:8] : smp[k/2][7:0];
      w[k % 2][31 - 8*(k/2) -: 8] = oct;
    end
    return w;
  endfunction

  // **************************************************
  // Checks and waits
  // **************************************************

  task automatic check_link(input logic [1:0][31:0] exp, input string what);
    checks++;
    if (link_data[0].word !== exp[0] || link_data[1].word !== exp[1]) begin
      errors++;
      $display("[FAIL] %0t: %s lane words %h %h, expected %h %h", $time, what,
               link_data[1].word, link_data[0].word, exp[1], exp[0]);
    end
  endtask

  task automatic check_level(input logic [1:0] got, input logic [1:0] exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic wait_link_valid(input int max_cycles, output int waited);
    int n;
    n = 0;
    while (!link_valid && n < max_cycles) begin
      @(negedge clk);
      n++;
    end
    waited = n;
    if (!link_valid) begin
      timed_out = 1'b1;
      $display("Timeout: link_valid still low %0d cycles after reset", max_cycles);
    end
  endtask

  task automatic print_test_result(input string name, input int chk0, input int err0);
    $display("Test %s done: %0d checks, %0d errors", name, checks - chk0, errors - err0);
  endtask

  // **************************************************
  // Tests
  // **************************************************

  task automatic test_reset();
    int c0;
    int e0;
    int waited;
    c0 = checks;
    e0 = errors;
    rst = 1'b1;
    cfg[0].data_sel = dac_tpl_pkg::src_dma;
    cfg[1].data_sel = dac_tpl_pkg::src_dma;
    for (int i = 0; i < 16; i++) begin
      @(negedge clk);
      check_link('0, "reset");
      check_level({1'b0, link_valid}, 2'b00, "link_valid in reset");
      check_level(dac_valid, 2'b00, "dac_valid in reset");
      check_level(enable, 2'b00, "enable in reset");
    end
    rst = 1'b0;
    wait_link_valid(8, waited);
    checks++;
    if (waited != 1) begin
      errors++;
      $display("[FAIL] %0t: link_valid rose after %0d cycles, expected 1", $time, waited);
    end
    // Pipeline still flushing
    check_link('0, "after reset");
    check_level(dac_valid, 2'b00, "dac_valid after reset");
    check_level(enable, 2'b00, "enable after reset");
    print_test_result("reset", c0, e0);
  endtask

  task automatic test_dma_passthrough();
    int c0;
    int e0;
    logic [1:0][31:0] hist [40];
    c0 = checks;
    e0 = errors;
    for (int i = 0; i < 40; i++) begin
      @(negedge clk);
      if (i >= 4) begin
        check_link(hist[i-4], "dma");
        check_level(enable, 2'b11, "dma enable");
        check_level(dac_valid, 2'b11, "dma dac_valid");
        check_level({1'b0, link_valid}, 2'b01, "dma link_valid");
      end
      cfg[0].data_sel = dac_tpl_pkg::src_dma;
      cfg[1].data_sel = dac_tpl_pkg::src_dma;
      dac_ddata = {$urandom, $urandom};
      // Sink readiness must not matter
      link_ready = ~link_ready;
      hist[i] = frame_words(dma_samples(dac_ddata));
    end
    print_test_result("dma_passthrough", c0, e0);
  endtask

  task automatic test_pattern_zero();
    int c0;
    int e0;
    c0 = checks;
    e0 = errors;
    for (int i = 0; i < 20; i++) begin
      @(negedge clk);
      if (i >= 4) begin
        check_link(frame_words({16'h0000, 16'h0000, 16'hc3e1, 16'h5aa5}), "pattern");
        check_level(enable, 2'b01, "pattern enable");
        check_level(dac_valid, 2'b01, "pattern dac_valid");
      end
      cfg[0].data_sel = dac_tpl_pkg::src_pattern;
      cfg[0].pat0 = 16'h5aa5;
      cfg[0].pat1 = 16'hc3e1;
      cfg[1].data_sel = dac_tpl_pkg::src_zero;
      dac_ddata = {$urandom, $urandom};
    end
    print_test_result("pattern_zero", c0, e0);
  endtask

  task automatic test_tone();
    int c0;
    int e0;
    logic fmt_hist [36];
    logic [3:0][15:0] smp;
    c0 = checks;
    e0 = errors;
    for (int i = 0; i < 36; i++) begin
      @(negedge clk);
      if (i >= 4) begin
        for (int c = 0; c < 2; c++) begin
          for (int s = 0; s < 2; s++) begin
            smp[2*c+s] = chan_tone(cfg[c], i - 4, s, fmt_hist[i-4]);
          end
        end
        check_link(frame_words(smp), "tone");
      end
      if (i == 0) begin
        // Scales 0.5, -0.375, 0.25 and 0.375 keep the sum in range
        cfg[0].data_sel = dac_tpl_pkg::src_tone;
        cfg[0].tone0 = '{scale: 16'h4000, init: 16'h0000, incr: 16'h0800};
        cfg[0].tone1 = '{scale: 16'hd000, init: 16'h4000, incr: 16'h1234};
        cfg[1].data_sel = dac_tpl_pkg::src_tone;
        cfg[1].tone0 = '{scale: 16'h2000, init: 16'h8000, incr: 16'h0321};
        cfg[1].tone1 = '{scale: 16'h3000, init: 16'hc123, incr: 16'hfedc};
      end
      dac_sync = (i == 0);
      // Switch to offset binary halfway
      dac_dds_format = (i >= 16);
      fmt_hist[i] = dac_dds_format;
    end
    print_test_result("tone", c0, e0);
  endtask

  task automatic test_ramp_resync();
    int c0;
    int e0;
    int last_sync;
    int start_hist [24];
    c0 = checks;
    e0 = errors;
    last_sync = 0;
    for (int i = 0; i < 24; i++) begin
      @(negedge clk);
      if (i >= 4) begin
        check_link(frame_words(ramp_samples(i - 4 - start_hist[i-4])), "ramp");
      end
      cfg[0].data_sel = dac_tpl_pkg::src_ramp;
      cfg[1].data_sel = dac_tpl_pkg::src_ramp;
      dac_sync = (i == 0 || i == 10);
      if (dac_sync) last_sync = i;
      start_hist[i] = last_sync;
    end
    dac_sync = 1'b0;
    print_test_result("ramp_resync", c0, e0);
  endtask

  initial begin
    clk = 1'b0;
    rst = 1'b1;
    dac_sync = 1'b0;
    dac_dds_format = 1'b0;
    cfg = '0;
    dac_ddata = '0;
    link_ready = 1'b0;
    checks = 0;
    errors = 0;
    timed_out = 1'b0;
    void'($urandom(32'hd8910e27));
    test_reset();
    if (!timed_out) begin
      test_dma_passthrough();
      test_pattern_zero();
      test_tone();
      test_ramp_resync();
    end
    $display("Total: %0d checks, %0d errors", checks, errors);
    if (errors == 0 && !timed_out) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

// ==== logic/dac_tpl_core.sv ====
// JESD204 DAC transport layer top: channel datapaths, framer, link and DMA status
`timescale 1ns/100ps

module dac_tpl_core (
  input  logic clk,
  input  logic rst,

  // Configuration
  input  logic dac_sync,
  input  logic dac_dds_format,
  input  dac_tpl_pkg::chan_cfg_t [dac_tpl_pkg::num_channels-1:0] cfg,

  // DMA side
  input  logic [dac_tpl_pkg::num_channels*dac_tpl_pkg::chan_w-1:0] dac_ddata,
  output logic [dac_tpl_pkg::num_channels-1:0] dac_valid,

  // Link side
  input  logic link_ready,
  output logic link_valid,
  output dac_tpl_pkg::lane_word_u [dac_tpl_pkg::num_lanes-1:0] link_data,

  output logic [dac_tpl_pkg::num_channels-1:0] enable
);

  dac_tpl_pkg::chan_samples_t [dac_tpl_pkg::num_channels-1:0] chan_data;
  dac_tpl_pkg::lane_word_u    [dac_tpl_pkg::num_lanes-1:0]    framed;

  // **************************************************
  // Channels
  // **************************************************

  // Channel c owns the 32 bits at 32c of the DMA bus
  for (genvar c = 0; c < dac_tpl_pkg::num_channels; c++) begin : g_channel
    dac_channel i_channel (
      .clk            (clk),
      .rst            (rst),
      .dac_sync       (dac_sync),
      .dac_dds_format (dac_dds_format),
      .cfg            (cfg[c]),
      .dma_data       (dac_ddata[c*dac_tpl_pkg::chan_w +: dac_tpl_pkg::chan_w]),
      .dac_data       (chan_data[c]),
      .enable         (enable[c])
    );
  end

  dac_framer i_framer (
    .clk       (clk),
    .rst       (rst),
    .chan_data (chan_data),
    .link_data (framed)
  );

  always_comb begin
    for (int l = 0; l < dac_tpl_pkg::num_lanes; l++) begin
      link_data[l].word = framed[l].word;
    end
  end

  // Free-running stream, valid once out of reset
  always_ff @(posedge clk) begin
    if (rst) begin
      link_valid <= 1'b0;
      dac_valid  <= '0;
    end else begin
      link_valid <= 1'b1;
      dac_valid  <= enable;
    end
  end

endmodule

// ==== logic/dac_framer.sv ====
// Registered octet interleaver from channel samples to big-endian lane words
`timescale 1ns/100ps

module dac_framer (
  input  logic                                                   clk,
  input  logic                                                   rst,
  input  dac_tpl_pkg::chan_samples_t [dac_tpl_pkg::num_channels-1:0] chan_data,
  output dac_tpl_pkg::lane_word_u    [dac_tpl_pkg::num_lanes-1:0]    link_data
);

  // All samples of the clock, channel 0 sample 0 in the low bytes
  logic [dac_tpl_pkg::frame_octets-1:0][7:0] frame;
  dac_tpl_pkg::lane_word_u [dac_tpl_pkg::num_lanes-1:0] lanes;

  assign frame = chan_data;

  // **************************************************
  // Octet mapping
  // **************************************************

  // Octet k in send order is the high byte of a sample when k is even,
  // so flipping bit 0 finds it in the little-endian frame
  // Lanes take octets round robin, first one into octet 3
  always_comb begin
    lanes = '0;
    for (int k = 0; k < dac_tpl_pkg::frame_octets; k++) begin
      lanes[k % dac_tpl_pkg::num_lanes]
        .octets[dac_tpl_pkg::lane_octets-1 - k / dac_tpl_pkg::num_lanes] = frame[k ^ 1];
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      link_data <= '0;
    end else begin
      link_data <= lanes;
    end
  end

  // Channels are still flushing zero when reset drops
  a_flush: assert property (@(posedge clk)
    $fell(rst) |=> (link_data == '0));

endmodule

// ==== logic/dac_channel.sv ====
// One DAC channel: tone generator, pattern, DMA, ramp and zero sources with matched latency
`timescale 1ns/100ps

module dac_channel (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       dac_sync,
  input  logic                       dac_dds_format,
  input  dac_tpl_pkg::chan_cfg_t     cfg,
  input  dac_tpl_pkg::chan_samples_t dma_data,
  output dac_tpl_pkg::chan_samples_t dac_data,
  output logic                       enable
);

  dac_tpl_pkg::chan_samples_t tone_data;
  dac_tpl_pkg::chan_samples_t ramp_data;
  dac_tpl_pkg::chan_samples_t aux_data;
  dac_tpl_pkg::chan_samples_t aux_d1;
  dac_tpl_pkg::chan_samples_t aux_d2;
  logic [dac_tpl_pkg::sample_w-1:0] ramp_cnt;
  logic [3:0] sel_d1;
  logic [3:0] sel_d2;

  dac_tone_gen i_tone_gen (
    .clk            (clk),
    .rst            (rst),
    .dac_sync       (dac_sync),
    .dac_dds_format (dac_dds_format),
    .tone0          (cfg.tone0),
    .tone1          (cfg.tone1),
    .tone_data      (tone_data)
  );

  // **************************************************
  // Ramp, runs in step with the tone accumulators
  // **************************************************

  always_comb begin
    ramp_data[0] = dac_sync ? '0 : ramp_cnt;
    for (int s = 1; s < dac_tpl_pkg::samples_per_clk; s++) begin
      ramp_data[s] = ramp_data[s-1] + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      ramp_cnt <= '0;
    end else begin
      ramp_cnt <= ramp_data[dac_tpl_pkg::samples_per_clk-1] + 1'b1;
    end
  end

  // **************************************************
  // Non-tone sources, delayed to the tone latency
  // **************************************************

  always_comb begin
    case (cfg.data_sel)
      dac_tpl_pkg::src_pattern: begin
        // Even samples take pat0, odd samples pat1
        for (int s = 0; s < dac_tpl_pkg::samples_per_clk; s++) begin
          aux_data[s] = (s % 2 == 0) ? cfg.pat0 : cfg.pat1;
        end
      end
      dac_tpl_pkg::src_dma:  aux_data = dma_data;
      dac_tpl_pkg::src_ramp: aux_data = ramp_data;
      default:               aux_data = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    aux_d1 <= aux_data;
    aux_d2 <= aux_d1;
  end

  // Select travels with the data, reset forces zero output
  always_ff @(posedge clk) begin
    if (rst) begin
      sel_d1 <= dac_tpl_pkg::src_zero;
      sel_d2 <= dac_tpl_pkg::src_zero;
      enable <= 1'b0;
    end else begin
      sel_d1 <= cfg.data_sel;
      sel_d2 <= sel_d1;
      enable <= (sel_d2 != dac_tpl_pkg::src_zero);
    end
  end

  // Output mux
  always_ff @(posedge clk) begin
    case (sel_d2)
      dac_tpl_pkg::src_tone:    dac_data <= tone_data;
      dac_tpl_pkg::src_pattern,
      dac_tpl_pkg::src_dma,
      dac_tpl_pkg::src_ramp:    dac_data <= aux_d2;
      default:                  dac_data <= '0;
    endcase
  end

  // Undefined select codes are a configuration error
  a_data_sel: assert property (@(posedge clk) disable iff (rst)
    cfg.data_sel <= dac_tpl_pkg::src_ramp);

endmodule

// ==== logic/dac_tone_gen.sv ====
// Two-tone sine generator: phase accumulators, quarter lookup, scale, sum and format
`timescale 1ns/100ps

module dac_tone_gen (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       dac_sync,
  input  logic                       dac_dds_format,
  input  dac_tpl_pkg::tone_cfg_t     tone0,
  input  dac_tpl_pkg::tone_cfg_t     tone1,
  output dac_tpl_pkg::chan_samples_t tone_data
);

  `include "dac_sine_table.svh"

  dac_tpl_pkg::tone_cfg_t [dac_tpl_pkg::num_tones-1:0] tone;

  // Base phase carried to the next clock
  logic [dac_tpl_pkg::num_tones-1:0][dac_tpl_pkg::phase_w-1:0] acc;

  // Phase of every sample this clock, sync restarts at init
  logic [dac_tpl_pkg::num_tones-1:0][dac_tpl_pkg::samples_per_clk-1:0]
        [dac_tpl_pkg::phase_w-1:0] phase;

  // Lookup stage
  logic [dac_tpl_pkg::num_tones-1:0][dac_tpl_pkg::samples_per_clk-1:0]
        [dac_tpl_pkg::sample_w-1:0] sine_q;
  logic fmt_q;

  // Scale-and-sum stage
  logic [dac_tpl_pkg::num_tones-1:0][dac_tpl_pkg::samples_per_clk-1:0]
        [2*dac_tpl_pkg::sample_w-1:0] prod;
  dac_tpl_pkg::chan_samples_t tone_sum;

  // Top phase byte: bit 7 negates, bit 6 mirrors, bits 5:0 index the quarter
  function automatic logic [15:0] sine_lookup(input logic [dac_tpl_pkg::phase_w-1:0] ph);
    logic [5:0]  idx;
    logic [15:0] amp;
    idx = ph[14] ? ~ph[13:8] : ph[13:8];
    amp = {1'b0, dac_sine_quarter[idx]};
    return ph[15] ? -amp : amp;
  endfunction

  assign tone = {tone1, tone0};

  // **************************************************
  // Phase accumulators
  // **************************************************

  always_comb begin
    for (int t = 0; t < dac_tpl_pkg::num_tones; t++) begin
      phase[t][0] = dac_sync ? tone[t].init : acc[t];
      for (int s = 1; s < dac_tpl_pkg::samples_per_clk; s++) begin
        phase[t][s] = phase[t][s-1] + tone[t].incr;
      end
    end
  end

  // Advance by one step per sample
  always_ff @(posedge clk) begin
    if (rst) begin
      acc <= '0;
    end else begin
      for (int t = 0; t < dac_tpl_pkg::num_tones; t++) begin
        acc[t] <= phase[t][dac_tpl_pkg::samples_per_clk-1] + tone[t].incr;
      end
    end
  end

  // **************************************************
  // Lookup, scale, sum
  // **************************************************

  always_ff @(posedge clk) begin
    fmt_q <= dac_dds_format;
    for (int t = 0; t < dac_tpl_pkg::num_tones; t++) begin
      for (int s = 0; s < dac_tpl_pkg::samples_per_clk; s++) begin
        sine_q[t][s] <= sine_lookup(phase[t][s]);
      end
    end
  end

  always_comb begin
    for (int s = 0; s < dac_tpl_pkg::samples_per_clk; s++) begin
      tone_sum[s] = '0;
      for (int t = 0; t < dac_tpl_pkg::num_tones; t++) begin
        prod[t][s] = $signed(tone[t].scale) * $signed(sine_q[t][s]);
        // Q1.15 product, arithmetic shift by 15 then wrap to 16 bits
        tone_sum[s] = tone_sum[s] + prod[t][s][30:15];
      end
      // Offset binary flips the sign bit
      tone_sum[s][dac_tpl_pkg::sample_w-1] = tone_sum[s][dac_tpl_pkg::sample_w-1] ^ fmt_q;
    end
  end

  always_ff @(posedge clk) begin
    tone_data <= tone_sum;
  end

  // Base phase one clock after a sync is init plus two steps
  a_sync_init: assert property (@(posedge clk) disable iff (rst)
    dac_sync ##1 !dac_sync |->
      (phase[0][0] == $past(tone0.init) + $past(tone0.incr) + $past(tone0.incr)) &&
      (phase[1][0] == $past(tone1.init) + $past(tone1.incr) + $past(tone1.incr)));

endmodule

// ==== logic/dac_tpl_pkg.sv ====
// Sizes, data source codes, channel configuration struct and lane word union
package dac_tpl_pkg;

  // **************************************************
  // Sizes
  // **************************************************

  localparam int num_lanes       = 2;
  localparam int num_channels    = 2;
  localparam int samples_per_clk = 2;
  localparam int num_tones       = 2;
  localparam int sample_w        = 16;
  localparam int phase_w         = 16;
  localparam int lane_w          = 32;

  // Bits of one channel's samples per clock
  localparam int chan_w       = samples_per_clk * sample_w;
  // Octets per lane word and per clock over all lanes
  localparam int lane_octets  = lane_w / 8;
  localparam int frame_octets = num_lanes * lane_octets;

  // Data select codes, anything else outputs zero
  localparam logic [3:0] src_tone    = 4'd0;
  localparam logic [3:0] src_pattern = 4'd1;
  localparam logic [3:0] src_dma     = 4'd2;
  localparam logic [3:0] src_zero    = 4'd3;
  localparam logic [3:0] src_ramp    = 4'd4;

  // **************************************************
  // Types
  // **************************************************

  // One tone: scale is signed Q1.15, phases in 1/65536 of a turn
  typedef struct packed {
    logic [sample_w-1:0] scale;
    logic [phase_w-1:0]  init;
    logic [phase_w-1:0]  incr;
  } tone_cfg_t;

  typedef struct packed {
    logic [3:0]          data_sel;
    tone_cfg_t           tone0;
    tone_cfg_t           tone1;
    logic [sample_w-1:0] pat0;
    logic [sample_w-1:0] pat1;
  } chan_cfg_t;

  // Sample 0 is the earlier one
  typedef logic [samples_per_clk-1:0][sample_w-1:0] chan_samples_t;

  // Octet 3 goes out on the lane first
  typedef union packed {
    logic [lane_w-1:0]                word;
    logic [lane_octets-1:0][7:0]      octets;
  } lane_word_u;

endpackage

// ==== include/dac_sine_table.svh ====
// Quarter-wave sine amplitude table for the tone generator
`ifndef dac_sine_table_svh
`define dac_sine_table_svh

// Entry k is round(32767 * sin(2*pi*(k+0.5)/256))
// Half-step offset makes the mirrored quarter symmetric
// so index ~k lands on the matching point of the next quarter
localparam logic [14:0] dac_sine_quarter [0:63] = '{
  15'd402,   15'd1206,  15'd2009,  15'd2811,
  15'd3612,  15'd4410,  15'd5205,  15'd5998,
  15'd6786,  15'd7571,  15'd8351,  15'd9126,
  15'd9896,  15'd10659, 15'd11417, 15'd12167,
  15'd12910, 15'd13645, 15'd14372, 15'd15090,
  15'd15800, 15'd16499, 15'd17189, 15'd17869,
  15'd18537, 15'd19195, 15'd19841, 15'd20475,
  15'd21096, 15'd21705, 15'd22301, 15'd22884,
  15'd23452, 15'd24007, 15'd24547, 15'd25072,
  15'd25582, 15'd26077, 15'd26556, 15'd27019,
  15'd27466, 15'd27896, 15'd28310, 15'd28706,
  15'd29085, 15'd29447, 15'd29791, 15'd30117,
  15'd30424, 15'd30714, 15'd30985, 15'd31237,
  15'd31470, 15'd31685, 15'd31880, 15'd32056,
  15'd32213, 15'd32351, 15'd32469, 15'd32567,
  15'd32646, 15'd32705, 15'd32745, 15'd32764
};

`endif
